//--- tetris_macros.svh
`ifndef TETRIS_MACROS_SVH
`define TETRIS_MACROS_SVH

// Playfield size
`define BOARD_ROWS 20
`define BOARD_COLS 10

// Index widths
`define ROW_BITS 5
`define COL_BITS 4

// Cleared-row counter width
`define LINE_CNT_BITS 8

`endif

//--- tetrisPkg.sv
`default_nettype none

package tetrisPkg;

    // Seven tetromino kinds, leftmost cell at column offset 0
    typedef enum logic [2:0] {
        line,      // Vertical 4x1
        square,    // 2x2
        lShape,
        reverseL,
        sShape,
        zShape,
        tShape
    } pieceKind;

    typedef enum logic [2:0] {
        spawn,     // Waiting for a piece
        fall,
        lock,
        clear,
        over       // Sticky until reset
    } gameState;

endpackage

`default_nettype wire

//--- gameSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module gameSequencer (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic pieceValid,
    output logic      pieceReady,
    input  wire logic spawnBlocked,
    input  wire logic landed,
    input  wire logic rowsFull,
    output logic      load,
    output logic      lockEn,
    output logic      clearEn,
    output logic      gameOver
);

    tetrisPkg::gameState state;
    tetrisPkg::gameState nextState;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state <= tetrisPkg::spawn;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            tetrisPkg::spawn: begin
                if (pieceValid) begin
                    // New piece overlapping the stack ends the game
                    nextState = spawnBlocked ? tetrisPkg::over : tetrisPkg::fall;
                end
            end
            tetrisPkg::fall: begin
                if (landed) begin
                    nextState = tetrisPkg::lock;
                end
            end
            tetrisPkg::lock: nextState = tetrisPkg::clear;  // Single lock cycle
            tetrisPkg::clear: begin
                if (!rowsFull) begin
                    nextState = tetrisPkg::spawn;
                end
            end
            tetrisPkg::over: nextState = tetrisPkg::over;
            default: nextState = tetrisPkg::spawn;
        endcase
    end

    assign pieceReady = (state == tetrisPkg::spawn);
    assign load = pieceReady && pieceValid;             // Handshake edge
    assign lockEn = (state == tetrisPkg::lock);
    assign clearEn = (state == tetrisPkg::clear);
    assign gameOver = (state == tetrisPkg::over);

endmodule

`default_nettype wire

//--- pieceDrop.sv
`timescale 1ns/1ps
`default_nettype none
`include "tetris_macros.svh"

module pieceDrop (
    input  wire logic                                   clk,
    input  wire logic                                   rst,
    input  wire logic                                   load,
    input  wire logic                                   tick,
    input  wire tetrisPkg::pieceKind                    loadKind,
    input  wire logic [`COL_BITS-1:0]                   loadCol,
    input  wire logic [`BOARD_ROWS-1:0][`BOARD_COLS-1:0] board,
    output logic [`BOARD_ROWS-1:0][`BOARD_COLS-1:0]      pieceMask,
    output logic                                        spawnBlocked,
    output logic                                        landed
);

    tetrisPkg::pieceKind kind;
    logic [`COL_BITS-1:0] col;
    logic [`ROW_BITS-1:0] row;
    logic active;                                       // Piece in flight
    logic settling;                                     // Landed, lock pending
    logic blocked;
    logic [`BOARD_ROWS-1:0][`BOARD_COLS-1:0] nextMask;

    // Cell pattern per kind, row r bit c is one cell
    function automatic logic [3:0][3:0] shapeCells(input tetrisPkg::pieceKind k);
        logic [3:0][3:0] cells;
        cells = '0;
        case (k)
            tetrisPkg::line: begin
                cells[0] = 4'b0001;
                cells[1] = 4'b0001;
                cells[2] = 4'b0001;
                cells[3] = 4'b0001;
            end
            tetrisPkg::square: begin
                cells[0] = 4'b0011;
                cells[1] = 4'b0011;
            end
            tetrisPkg::lShape: begin
                cells[0] = 4'b0001;
                cells[1] = 4'b0001;
                cells[2] = 4'b0011;
            end
            tetrisPkg::reverseL: begin
                cells[0] = 4'b0010;
                cells[1] = 4'b0010;
                cells[2] = 4'b0011;
            end
            tetrisPkg::sShape: begin
                cells[0] = 4'b0110;
                cells[1] = 4'b0011;
            end
            tetrisPkg::zShape: begin
                cells[0] = 4'b0011;
                cells[1] = 4'b0110;
            end
            tetrisPkg::tShape: begin
                cells[0] = 4'b0010;
                cells[1] = 4'b0111;
            end
            default: cells = '0;
        endcase
        return cells;
    endfunction

    // Rows spanned by the shape
    function automatic int shapeHeight(input tetrisPkg::pieceKind k);
        logic [3:0][3:0] cells;
        int h;
        cells = shapeCells(k);
        h = 0;
        for (int r = 0; r < 4; r++) begin
            if (|cells[r]) begin
                h = r + 1;
            end
        end
        return h;
    endfunction

    // Draw a shape on an empty board, off-board cells dropped
    function automatic logic [`BOARD_ROWS-1:0][`BOARD_COLS-1:0] renderMask(
        input tetrisPkg::pieceKind k,
        input int rowPos,
        input int colPos
    );
        logic [3:0][3:0] cells;
        logic [`BOARD_ROWS-1:0][`BOARD_COLS-1:0] m;
        cells = shapeCells(k);
        m = '0;
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                if (cells[r][c] && (rowPos + r < `BOARD_ROWS) && (colPos + c < `BOARD_COLS)) begin
                    m[rowPos + r][colPos + c] = 1'b1;
                end
            end
        end
        return m;
    endfunction

    always_comb begin
        nextMask = renderMask(kind, int'(row) + 1, int'(col));
        // Floor reached or locked cells one row below
        blocked = (int'(row) + shapeHeight(kind) >= `BOARD_ROWS) || (|(nextMask & board));
    end

    assign pieceMask = active ? renderMask(kind, int'(row), int'(col)) : '0;
    assign spawnBlocked = |(renderMask(loadKind, 0, int'(loadCol)) & board);
    assign landed = active && !settling && tick && blocked;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            row <= '0;
            active <= 1'b0;
            settling <= 1'b0;
        end else if (load) begin
            row <= '0;
            active <= !spawnBlocked;                    // Overlapping spawn never flies
            settling <= 1'b0;
        end else if (settling) begin
            active <= 1'b0;                             // Cells now live in the board
            settling <= 1'b0;
        end else if (active && tick) begin
            if (blocked) begin
                settling <= 1'b1;
            end else begin
                row <= row + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            kind <= loadKind;
            col <= loadCol;
        end
    end

endmodule

`default_nettype wire

//--- playfieldStore.sv
`timescale 1ns/1ps
`default_nettype none
`include "tetris_macros.svh"

module playfieldStore (
    input  wire logic                                   clk,
    input  wire logic                                   rst,
    input  wire logic                                   lockEn,
    input  wire logic                                   clearEn,
    input  wire logic [`BOARD_ROWS-1:0][`BOARD_COLS-1:0] pieceMask,
    input  wire logic [`ROW_BITS-1:0]                   readRow,
    output logic [`BOARD_ROWS-1:0][`BOARD_COLS-1:0]      board,
    output logic                                        rowsFull,
    output logic [`BOARD_COLS-1:0]                      boardRow,
    output logic [`LINE_CNT_BITS-1:0]                   linesCleared
);

    logic [`BOARD_ROWS-1:0] rowFull;
    logic [`ROW_BITS-1:0] lowestFull;                   // Largest index of a full row
    logic [`BOARD_ROWS-1:0][`BOARD_COLS-1:0] collapsed;

    always_comb begin
        lowestFull = '0;
        for (int r = 0; r < `BOARD_ROWS; r++) begin
            rowFull[r] = &board[r];
            if (rowFull[r]) begin
                lowestFull = `ROW_BITS'(r);             // Later rows sit lower
            end
        end
    end

    assign rowsFull = |rowFull;

    // Board with the lowest full row removed
    always_comb begin
        for (int r = 0; r < `BOARD_ROWS; r++) begin
            if (r > int'(lowestFull)) begin
                collapsed[r] = board[r];                // Below the cleared row
            end else if (r == 0) begin
                collapsed[r] = '0;                      // Fresh empty top row
            end else begin
                collapsed[r] = board[r - 1];
            end
        end
    end

    assign boardRow = (readRow < `BOARD_ROWS) ? board[readRow] : '0;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            board <= '0;
            linesCleared <= '0;
        end else if (lockEn) begin
            board <= board | pieceMask;
        end else if (clearEn && rowsFull) begin
            board <= collapsed;
            linesCleared <= linesCleared + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- tetrisTop.sv
`timescale 1ns/1ps
`default_nettype none
`include "tetris_macros.svh"

module tetrisTop (
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire logic                     pieceValid,
    output logic                          pieceReady,
    input  wire tetrisPkg::pieceKind      pieceKind,
    input  wire logic [`COL_BITS-1:0]     pieceCol,
    input  wire logic                     tick,
    input  wire logic [`ROW_BITS-1:0]     readRow,
    output logic [`BOARD_COLS-1:0]        boardRow,
    output logic [`LINE_CNT_BITS-1:0]     linesCleared,
    output logic                          gameOver
);

    logic [`BOARD_ROWS-1:0][`BOARD_COLS-1:0] board;     // Locked cells
    logic [`BOARD_ROWS-1:0][`BOARD_COLS-1:0] pieceMask; // Falling piece
    logic spawnBlocked;
    logic landed;
    logic rowsFull;
    logic load;
    logic lockEn;
    logic clearEn;

    gameSequencer sequencer (
        .clk          (clk),
        .rst          (rst),
        .pieceValid   (pieceValid),
        .pieceReady   (pieceReady),
        .spawnBlocked (spawnBlocked),
        .landed       (landed),
        .rowsFull     (rowsFull),
        .load         (load),
        .lockEn       (lockEn),
        .clearEn      (clearEn),
        .gameOver     (gameOver)
    );

    pieceDrop dropper (
        .clk          (clk),
        .rst          (rst),
        .load         (load),
        .tick         (tick),
        .loadKind     (pieceKind),
        .loadCol      (pieceCol),
        .board        (board),
        .pieceMask    (pieceMask),
        .spawnBlocked (spawnBlocked),
        .landed       (landed)
    );

    playfieldStore playfield (
        .clk          (clk),
        .rst          (rst),
        .lockEn       (lockEn),
        .clearEn      (clearEn),
        .pieceMask    (pieceMask),
        .readRow      (readRow),
        .board        (board),
        .rowsFull     (rowsFull),
        .boardRow     (boardRow),
        .linesCleared (linesCleared)
    );

endmodule

`default_nettype wire

//--- tb_tetrisTop.sv
`timescale 1ns/1ps
`default_nettype none
`include "tetris_macros.svh"

module tb_tetrisTop;

    localparam int NUM_STEPS = 29;
    localparam int TIMEOUT_NS = NUM_STEPS * 25 * 4 * 10 + 10000;

    // Each word is {reset, kind[2:0], col[3:0], expected linesCleared[7:0]}
    localparam logic [NUM_STEPS*16-1:0] STEP_TABLE = {
        16'h8000, 16'h9300, 16'ha800, 16'hb500, 16'hc700, 16'hd000, 16'he400, // Kinds alone
        16'h9000, 16'h1000, 16'h0400, 16'h0400, 16'h6300,                     // Stacking
        16'h9000, 16'h1200, 16'h1400, 16'h1600, 16'h2801,                     // One row
        16'h1001, 16'h1201, 16'h1401, 16'h1601, 16'h0903,                     // Two rows
        16'h8000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h1500  // Overflow
    };

    logic clk;
    logic rst;
    logic pieceValid;
    logic pieceReady;
    tetrisPkg::pieceKind pieceKind;
    logic [`COL_BITS-1:0] pieceCol;
    logic tick;
    logic [`ROW_BITS-1:0] readRow;
    logic [`BOARD_COLS-1:0] boardRow;
    logic [`LINE_CNT_BITS-1:0] linesCleared;
    logic gameOver;

    logic [`BOARD_COLS-1:0] model [`BOARD_ROWS];       // Bit c is column c
    logic modelOver;
    logic [15:0] step;
    int errorCount;

    tetrisTop uut (.*);

    always #5 clk = ~clk;

    // Four cells per kind, each nibble is row * 4 + col
    function automatic logic [15:0] cellOffsets(input tetrisPkg::pieceKind k);
        case (k)
            tetrisPkg::line:     return 16'h048c;
            tetrisPkg::square:   return 16'h0145;
            tetrisPkg::lShape:   return 16'h0489;
            tetrisPkg::reverseL: return 16'h1598;
            tetrisPkg::sShape:   return 16'h1245;
            tetrisPkg::zShape:   return 16'h0156;
            default:             return 16'h1456;      // T piece
        endcase
    endfunction

    function automatic logic fitsAt(input tetrisPkg::pieceKind k, input int col, input int row);
        logic [15:0] offs;
        int r;
        int c;
        offs = cellOffsets(k);
        for (int i = 0; i < 4; i++) begin
            r = row + int'(offs[i*4+2 +: 2]);
            c = col + int'(offs[i*4 +: 2]);
            if (r >= `BOARD_ROWS || model[r][c]) begin
                return 1'b0;                            // Floor or locked cell
            end
        end
        return 1'b1;
    endfunction

    // Straight drop, lock, then full rows removed lowest first
    task automatic modelDrop(input tetrisPkg::pieceKind k, input int col);
        logic [15:0] offs;
        int row;
        int r;
        offs = cellOffsets(k);
        row = 0;
        if (!fitsAt(k, col, 0)) begin
            modelOver = 1'b1;
        end else begin
            while (fitsAt(k, col, row + 1)) begin
                row++;
            end
            for (int i = 0; i < 4; i++) begin
                model[row + int'(offs[i*4+2 +: 2])][col + int'(offs[i*4 +: 2])] = 1'b1;
            end
            r = `BOARD_ROWS - 1;
            while (r >= 0) begin
                if (&model[r]) begin
                    for (int s = r; s > 0; s--) begin
                        model[s] = model[s - 1];
                    end
                    model[0] = '0;                      // Same index checked again
                end else begin
                    r--;
                end
            end
        end
    endtask

    task automatic reportMismatch(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
        $display("[ERROR] %0t %s expected 0x%0h actual 0x%0h", $time, name, expected, actual);
        errorCount++;
    endtask

    task automatic applyReset();
        @(posedge clk);
        #1 rst = 1'b1;
        repeat (2) @(posedge clk);
        #1 rst = 1'b0;
        modelOver = 1'b0;
        for (int r = 0; r < `BOARD_ROWS; r++) begin
            model[r] = '0;
        end
    endtask

    // Status outputs, then one board row per cycle
    task automatic checkState(input logic [`LINE_CNT_BITS-1:0] expLines);
        if (linesCleared !== expLines) begin
            reportMismatch("linesCleared", expLines, linesCleared);
        end
        if (gameOver !== modelOver) begin
            reportMismatch("gameOver", modelOver, gameOver);
        end
        if (pieceReady !== !modelOver) begin
            reportMismatch("pieceReady", !modelOver, pieceReady);
        end
        for (int r = 0; r < `BOARD_ROWS; r++) begin
            @(posedge clk);
            #1 readRow = `ROW_BITS'(r);
            #4;
            if (boardRow !== model[r]) begin
                reportMismatch($sformatf("boardRow[%0d]", r), model[r], boardRow);
            end
        end
    endtask

    task automatic playPiece(input tetrisPkg::pieceKind k, input logic [`COL_BITS-1:0] col);
        int cycles;
        logic wasOver;
        wasOver = modelOver;
        cycles = 0;
        repeat (2) begin
            @(posedge clk);
            #1 tick = 1'b1;                             // Gravity while idle
        end
        @(posedge clk);
        #1 tick = 1'b0;
        while (pieceReady !== 1'b1 && gameOver !== 1'b1) begin
            @(posedge clk);
            #1;
        end
        pieceValid = 1'b1;
        pieceKind = k;
        pieceCol = col;
        if (wasOver) begin
            repeat (8) begin
                @(posedge clk);
                #1 tick = (cycles % 4 == 3);
                cycles++;
                if (pieceReady !== 1'b0) begin
                    reportMismatch("pieceReady", 0, pieceReady);
                end
            end
        end else begin
            @(posedge clk);
            #1 pieceValid = 1'b0;
            while (pieceReady !== 1'b1 && gameOver !== 1'b1) begin
                cycles++;
                tick = (cycles % 4 == 0);               // Every fourth cycle
                @(posedge clk);
                #1;
            end
            modelDrop(k, int'(col));
        end
        pieceValid = 1'b0;
        tick = 1'b0;
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the core stopped answering before the table was finished");
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        pieceValid = 1'b0;
        pieceKind = tetrisPkg::line;
        pieceCol = '0;
        tick = 1'b0;
        readRow = '0;
        modelOver = 1'b0;
        errorCount = 0;
        for (int i = 0; i < NUM_STEPS; i++) begin
            step = STEP_TABLE[(NUM_STEPS - 1 - i) * 16 +: 16];
            if (step[15]) begin
                applyReset();
                checkState('0);                         // Empty board after reset
            end
            playPiece(tetrisPkg::pieceKind'(step[14:12]), step[11:8]);
            checkState(step[7:0]);
        end
        $display("Finished %0d table entries with %0d errors", NUM_STEPS, errorCount);
        if (errorCount == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+.
tetrisPkg.sv
gameSequencer.sv
pieceDrop.sv
playfieldStore.sv
tetrisTop.sv
tb_tetrisTop.sv
